// ==== rtl/adec_pkg.sv ====
// Address decode types for region, bank, size code and region limit, plus decode constants
`default_nettype none

package adec_pkg;

  // Region index from address bits 23..20, one region per MB
  typedef logic [3:0] region_t;

  // Bank number to the memory array
  typedef logic [2:0] bank_t;

  // Installed size code
  // 0 none, 1 is 2 MB, 2 is 4 MB, 3 is 6 MB
  typedef logic [1:0] msize_t;

  // Count of regions fitted
  typedef logic [3:0] limit_t;

  // Regions in the 24-bit space
  localparam int unsigned NUM_REGIONS = 16;

  // Size code with no memory fitted
  localparam msize_t MSIZE_NONE = 2'd0;

endpackage : adec_pkg

`default_nettype wire

// ==== rtl/req_pkg.sv ====
// Request controller state enum, active-low line level type and level constants
`default_nettype none

package req_pkg;

  // Four-phase request FSM states
  typedef enum logic [1:0] {
    REQ_IDLE         = 2'd0,  // No request pending
    REQ_ASSERT       = 2'd1,  // Request low, waiting for grant
    REQ_WAIT_RELEASE = 2'd2   // Request released, waiting for grant to drop
  } req_state_e;

  // Level on an active-low request or grant line
  typedef logic lvl_n_t;

  localparam lvl_n_t LVL_ON  = 1'b0;  // Line asserted
  localparam lvl_n_t LVL_OFF = 1'b1;  // Line idle

endpackage : req_pkg

`default_nettype wire

// ==== rtl/mem_size_cfg.sv ====
// Installed memory size register, memory-off switch synchronizer and region limit
`timescale 1ns/1ns
`default_nettype none

module mem_size_cfg #(
  parameter int unsigned SIZE_STEP = 2         // Regions added per size code
) (
  input  wire                   clk,
  input  wire                   arst_n,        // Async reset, active low
  input  wire                   cfg_we,        // Size register write enable
  input  wire adec_pkg::msize_t cfg_msize,     // New size code
  input  wire                   moff_sw_n,     // Memory-off switch
  output adec_pkg::limit_t      limit,         // Regions fitted
  output logic                  mem_on,        // Hits allowed
  output logic                  moff_n         // Synchronized switch level
);

  adec_pkg::msize_t msize_q;                   // Installed size code
  logic [1:0]       moff_sync;                 // Two-flop switch synchronizer
  logic [5:0]       limit_wide;                // Full product before narrowing

  // Size register, written from outside
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      msize_q <= adec_pkg::MSIZE_NONE;         // No hits until configured
    end else if (cfg_we) begin
      msize_q <= cfg_msize;                    // Takes effect this edge
    end
  end

  // Switch comes from a panel contact, so bring it into clk domain
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      moff_sync <= 2'b11;                      // Switch rests high
    end else begin
      moff_sync <= {moff_sync[0], moff_sw_n};
    end
  end

  assign limit_wide = 6'(SIZE_STEP) * 6'(msize_q);
  assign limit      = limit_wide[3:0];         // Upper bits zero when legal
  assign moff_n     = moff_sync[1];
  assign mem_on     = moff_sync[1] & (msize_q != adec_pkg::MSIZE_NONE);

  // Region limit must stay within the address space for any code and step
  a_limit_in_range : assert property (
    @(posedge clk) disable iff (!arst_n)
    limit_wide < adec_pkg::NUM_REGIONS
  ) else $error("region limit %0d exceeds address space", limit_wide);

endmodule : mem_size_cfg

`default_nettype wire

// ==== rtl/cpu_adec.sv ====
// CPU-side address decoder with registered bank, write strobe, hit and request start
`timescale 1ns/1ns
`default_nettype none

module cpu_adec (
  input  wire                    clk,
  input  wire                    arst_n,         // Async reset, active low
  input  wire                    cpu_strobe,     // Address valid this cycle
  input  wire                    iorq_n,         // Low for I/O cycle
  input  wire                    write,          // CPU write cycle
  input  wire adec_pkg::region_t ppn,            // Physical page region
  input  wire adec_pkg::limit_t  limit,          // Regions fitted
  input  wire                    mem_on,         // Memory enabled
  output adec_pkg::bank_t        bank,           // Bank to memory array
  output logic                   mwrite_n,       // Memory write, active low
  output logic                   crq_n,          // CPU hit, active low
  output logic                   cpu_hit_start   // One-cycle start to request FSM
);

  logic mem_acc;                                 // Memory cycle, not I/O
  logic in_range;                                // Region below limit
  logic hit;                                     // Access lands on this board

  assign mem_acc  = iorq_n;
  assign in_range = ppn < limit;
  assign hit      = mem_acc & mem_on & in_range;

  // Decode results register on the strobe edge and hold until the next one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bank          <= '0;
      mwrite_n      <= 1'b1;
      crq_n         <= 1'b1;
      cpu_hit_start <= 1'b0;
    end else begin
      cpu_hit_start <= 1'b0;                     // Pulse by default
      if (cpu_strobe) begin
        if (mem_acc) begin
          bank <= ppn[2:0];                      // I/O keeps last bank
        end
        crq_n         <= ~hit;
        mwrite_n      <= ~(hit & write);         // Only a hitting write
        cpu_hit_start <= hit;
      end
    end
  end

  // Write strobe never fires on a miss
  a_write_needs_hit : assert property (
    @(posedge clk) disable iff (!arst_n)
    !mwrite_n |-> !crq_n
  ) else $error("mwrite_n low without a CPU hit");

endmodule : cpu_adec

`default_nettype wire

// ==== rtl/bus_adec.sv ====
// Bus-side address decoder with registered address-ok, bank and request start
`timescale 1ns/1ns
`default_nettype none

module bus_adec (
  input  wire                    clk,
  input  wire                    arst_n,         // Async reset, active low
  input  wire                    bus_strobe,     // Bus address valid
  input  wire                    bmem_n,         // Memory cycle, active low
  input  wire                    binput_n,       // Input cycle, active low
  input  wire adec_pkg::region_t bd_n,           // Bus region, inverted on the bus
  input  wire adec_pkg::limit_t  limit,          // Regions fitted
  input  wire                    mem_on,         // Memory enabled
  output adec_pkg::bank_t        bus_bank,       // Bank for bus access
  output logic                   aok,            // Address on this board
  output logic                   bus_hit_start   // One-cycle start to request FSM
);

  adec_pkg::region_t region;                     // True-polarity region
  logic              mem_cycle;                  // Memory cycle that is not input
  logic              addr_ok;                    // Next aok value

  assign region    = ~bd_n;
  assign mem_cycle = ~bmem_n & binput_n;
  assign addr_ok   = mem_cycle & mem_on & (region < limit);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus_bank      <= '0;
      aok           <= 1'b0;
      bus_hit_start <= 1'b0;
    end else begin
      bus_hit_start <= 1'b0;
      if (bus_strobe) begin
        aok           <= addr_ok;                // Other cycles clear it
        bus_hit_start <= addr_ok;
        if (mem_cycle) begin
          bus_bank <= region[2:0];
        end
      end
    end
  end

endmodule : bus_adec

`default_nettype wire

// ==== rtl/local_req_ctrl.sv ====
// Four-phase local memory request FSM, one instance per requester
`timescale 1ns/1ns
`default_nettype none

module local_req_ctrl (
  input  wire  clk,
  input  wire  arst_n,                           // Async reset, active low
  input  wire  start,                            // One-cycle request start
  input  wire  gnt_n,                            // Grant from arbiter, active low
  output logic lrq_n                             // Local request, active low
);

  req_pkg::req_state_e state;
  req_pkg::req_state_e state_nxt;
  req_pkg::lvl_n_t     lrq_nxt;

  always_comb begin
    state_nxt = state;
    lrq_nxt   = lrq_n;
    case (state)
      req_pkg::REQ_IDLE: begin
        if (start) begin
          state_nxt = req_pkg::REQ_ASSERT;
          lrq_nxt   = req_pkg::LVL_ON;          // Raise request
        end
      end
      req_pkg::REQ_ASSERT: begin
        if (gnt_n == req_pkg::LVL_ON) begin
          state_nxt = req_pkg::REQ_WAIT_RELEASE;
          lrq_nxt   = req_pkg::LVL_OFF;         // Drop on grant seen
        end
      end
      req_pkg::REQ_WAIT_RELEASE: begin
        if (gnt_n == req_pkg::LVL_OFF) begin
          state_nxt = req_pkg::REQ_IDLE;        // Arbiter done
        end
      end
      default: begin
        state_nxt = req_pkg::REQ_IDLE;
        lrq_nxt   = req_pkg::LVL_OFF;
      end
    endcase
  end

  // Starts outside REQ_IDLE fall through the case and are lost
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= req_pkg::REQ_IDLE;
      lrq_n <= req_pkg::LVL_OFF;
    end else begin
      state <= state_nxt;
      lrq_n <= lrq_nxt;
    end
  end

  // Request line stays released while the grant drains
  a_no_req_in_release : assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == req_pkg::REQ_WAIT_RELEASE) |-> (lrq_n == req_pkg::LVL_OFF)
  ) else $error("lrq_n low in REQ_WAIT_RELEASE");

  // No way out of REQ_ASSERT without a grant
  a_assert_holds : assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == req_pkg::REQ_ASSERT && gnt_n == req_pkg::LVL_OFF)
      |=> (state == req_pkg::REQ_ASSERT)
  ) else $error("left REQ_ASSERT without grant");

endmodule : local_req_ctrl

`default_nettype wire

// ==== rtl/mem_adec.sv ====
// Memory address decode top with size register, CPU and bus decoders and request FSMs
`timescale 1ns/1ns
`default_nettype none

module mem_adec #(
  parameter int unsigned SIZE_STEP = 2           // Regions added per size code
) (
  input  wire                    clk,
  input  wire                    arst_n,         // Async reset, active low
  input  wire                    cfg_we,         // Size register write
  input  wire adec_pkg::msize_t  cfg_msize,      // Size code to load
  input  wire                    moff_sw_n,      // Memory-off switch
  input  wire                    cpu_strobe,
  input  wire                    iorq_n,
  input  wire                    write,
  input  wire adec_pkg::region_t ppn,
  input  wire                    bus_strobe,
  input  wire                    bmem_n,
  input  wire                    binput_n,
  input  wire adec_pkg::region_t bd_n,
  input  wire                    refrq_n,        // Refresh request, active low
  input  wire                    cgnt_n,         // CPU grant
  input  wire                    bgnt_n,         // Bus grant
  input  wire                    rgnt_n,         // Refresh grant
  output adec_pkg::bank_t        bank,
  output logic                   mwrite_n,
  output logic                   crq_n,
  output logic                   clrq_n,         // CPU local request
  output adec_pkg::bank_t        bus_bank,
  output logic                   aok,
  output logic                   blrq_n,         // Bus local request
  output logic                   rlrq_n,         // Refresh local request
  output logic                   moff_n
);

  adec_pkg::limit_t limit;
  logic             mem_on;
  logic             cpu_hit_start;
  logic             bus_hit_start;
  logic [1:0]       refrq_hist;                  // [0] newest sample
  logic             refresh_start;

  // Falling edge of refrq_n seen across two samples
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      refrq_hist <= 2'b11;
    end else begin
      refrq_hist <= {refrq_hist[0], refrq_n};
    end
  end

  assign refresh_start = refrq_hist[1] & ~refrq_hist[0];

  mem_size_cfg #(
    .SIZE_STEP (SIZE_STEP)
  ) u_size_cfg (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_we    (cfg_we),
    .cfg_msize (cfg_msize),
    .moff_sw_n (moff_sw_n),
    .limit     (limit),
    .mem_on    (mem_on),
    .moff_n    (moff_n)
  );

  cpu_adec u_cpu_adec (
    .clk           (clk),
    .arst_n        (arst_n),
    .cpu_strobe    (cpu_strobe),
    .iorq_n        (iorq_n),
    .write         (write),
    .ppn           (ppn),
    .limit         (limit),
    .mem_on        (mem_on),
    .bank          (bank),
    .mwrite_n      (mwrite_n),
    .crq_n         (crq_n),
    .cpu_hit_start (cpu_hit_start)
  );

  bus_adec u_bus_adec (
    .clk           (clk),
    .arst_n        (arst_n),
    .bus_strobe    (bus_strobe),
    .bmem_n        (bmem_n),
    .binput_n      (binput_n),
    .bd_n          (bd_n),
    .limit         (limit),
    .mem_on        (mem_on),
    .bus_bank      (bus_bank),
    .aok           (aok),
    .bus_hit_start (bus_hit_start)
  );

  // One request FSM per requester towards the external arbiter
  local_req_ctrl u_creq (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (cpu_hit_start),
    .gnt_n  (cgnt_n),
    .lrq_n  (clrq_n)
  );

  local_req_ctrl u_breq (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (bus_hit_start),
    .gnt_n  (bgnt_n),
    .lrq_n  (blrq_n)
  );

  local_req_ctrl u_rreq (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (refresh_start),
    .gnt_n  (rgnt_n),
    .lrq_n  (rlrq_n)
  );

endmodule : mem_adec

`default_nettype wire

// ==== sim/tb_mem_adec.sv ====
// Testbench for mem_adec with reference decode, compare tasks, handshake checks and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_mem_adec;

  localparam int unsigned SIZE_STEP  = 2;
  localparam int          N_PER_CODE = 12;                   // Access pairs per phase
  localparam int          N_TRANS    = 2 * (4 + 10 * N_PER_CODE) + 12;

  logic              clk;
  logic              arst_n;
  logic              cfg_we;
  adec_pkg::msize_t  cfg_msize;
  logic              moff_sw_n;
  logic              cpu_strobe;
  logic              iorq_n;
  logic              write;
  adec_pkg::region_t ppn;
  logic              bus_strobe;
  logic              bmem_n;
  logic              binput_n;
  adec_pkg::region_t bd_n;
  logic              refrq_n;
  logic              cgnt_n;
  logic              bgnt_n;
  logic              rgnt_n;
  adec_pkg::bank_t   bank;
  logic              mwrite_n;
  logic              crq_n;
  logic              clrq_n;
  adec_pkg::bank_t   bus_bank;
  logic              aok;
  logic              blrq_n;
  logic              rlrq_n;
  logic              moff_n;

  int                errors     = 0;
  int                checks     = 0;
  int                clrq_falls = 0;                         // Falling edges of clrq_n
  int                seed;
  logic              auto_gnt;                               // Grant model active
  adec_pkg::msize_t  cur_msize;                              // Size code held by DUT
  logic              sw_on;                                  // Synchronized switch level
  adec_pkg::bank_t   cpu_bank_exp;
  adec_pkg::bank_t   bus_bank_exp;
  logic [4:0]        cpu_exp_q[$];                           // {hit, write hit, bank}
  logic [4:0]        bus_exp_q[$];

  mem_adec #(
    .SIZE_STEP (SIZE_STEP)
  ) u_mem_adec (
    .clk (clk), .arst_n (arst_n), .cfg_we (cfg_we), .cfg_msize (cfg_msize),
    .moff_sw_n (moff_sw_n), .cpu_strobe (cpu_strobe), .iorq_n (iorq_n), .write (write),
    .ppn (ppn), .bus_strobe (bus_strobe), .bmem_n (bmem_n), .binput_n (binput_n),
    .bd_n (bd_n), .refrq_n (refrq_n), .cgnt_n (cgnt_n), .bgnt_n (bgnt_n), .rgnt_n (rgnt_n),
    .bank (bank), .mwrite_n (mwrite_n), .crq_n (crq_n), .clrq_n (clrq_n),
    .bus_bank (bus_bank), .aok (aok), .blrq_n (blrq_n), .rlrq_n (rlrq_n), .moff_n (moff_n)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                                   // 10 ns period
  end

  always @(negedge clrq_n) begin
    clrq_falls = clrq_falls + 1;
  end

  // Expected decode from region, size code, switch, step and access type
  function automatic logic [4:0] ref_decode(input adec_pkg::region_t region,
                                            input adec_pkg::msize_t msize, input logic sw,
                                            input logic mem_acc, input logic wr,
                                            input adec_pkg::bank_t prev_bank);
    int unsigned     fitted;
    logic            hit;
    adec_pkg::bank_t bnk;
    fitted = SIZE_STEP * msize;                              // 1 MB regions fitted
    hit    = mem_acc && sw && (msize != 0) && (region < fitted);
    bnk    = mem_acc ? region[2:0] : prev_bank;              // Non-memory keeps bank
    return {hit, hit & wr, bnk};
  endfunction

  task automatic check_bank(input adec_pkg::bank_t got, input adec_pkg::bank_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_region_limit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s hit is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input req_pkg::lvl_n_t got, input req_pkg::lvl_n_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL %0t ns: %s counted %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Compares decoder outputs after each strobe edge
  initial begin : compare_outputs
    logic       cpu_due;
    logic       bus_due;
    logic [4:0] exp;
    forever begin
      @(posedge clk);
      cpu_due = cpu_strobe;                                  // Strobe sampled this edge
      bus_due = bus_strobe;
      @(negedge clk);
      if (cpu_due && cpu_exp_q.size() == 0) begin
        errors++;
        $display("CPU strobe at %0t ns had no expected result queued", $time);
      end else if (cpu_due) begin
        exp = cpu_exp_q.pop_front();
        check_region_limit(~crq_n, exp[4], "CPU decode");
        check_level(mwrite_n, ~exp[3], "mwrite_n");
        check_bank(bank, exp[2:0], "bank");
      end
      if (bus_due && bus_exp_q.size() == 0) begin
        errors++;
        $display("Bus strobe at %0t ns had no expected result queued", $time);
      end else if (bus_due) begin
        exp = bus_exp_q.pop_front();
        check_region_limit(aok, exp[4], "bus aok");
        check_bank(bus_bank, exp[2:0], "bus_bank");
      end
    end
  end

  // Arbiter stand-in, grant mirrors request one cycle later
  initial begin : grant_model
    forever begin
      @(posedge clk);
      #1;
      if (auto_gnt) begin
        cgnt_n = clrq_n;
        bgnt_n = blrq_n;
        rgnt_n = rlrq_n;
      end
    end
  end

  initial begin : watchdog
    repeat (N_TRANS * 200) @(posedge clk);
    $display("Timeout: run still going after %0d cycles", N_TRANS * 200);
    $display("TB FAILED");
    $finish;
  end

  task automatic write_size(input adec_pkg::msize_t code);
    @(posedge clk);
    #1;
    cfg_we    = 1'b1;
    cfg_msize = code;
    @(posedge clk);
    #1;
    cfg_we    = 1'b0;
    cur_msize = code;                                        // Loaded at edge just passed
  endtask

  task automatic cpu_access(input adec_pkg::region_t region, input logic io, input logic wr);
    logic [4:0] exp;
    @(posedge clk);
    #1;
    cpu_strobe   = 1'b1;
    iorq_n       = ~io;
    write        = wr;
    ppn          = region;
    exp          = ref_decode(region, cur_msize, sw_on, ~io, wr, cpu_bank_exp);
    cpu_bank_exp = exp[2:0];
    cpu_exp_q.push_back(exp);
    @(posedge clk);
    #1;
    cpu_strobe = 1'b0;
  endtask

  task automatic bus_access(input adec_pkg::region_t bd, input logic mem_n, input logic in_n);
    logic [4:0] exp;
    @(posedge clk);
    #1;
    bus_strobe   = 1'b1;
    bmem_n       = mem_n;
    binput_n     = in_n;
    bd_n         = bd;
    exp          = ref_decode(~bd, cur_msize, sw_on, ~mem_n & in_n, 1'b0, bus_bank_exp);
    bus_bank_exp = exp[2:0];
    bus_exp_q.push_back(exp);
    @(posedge clk);
    #1;
    bus_strobe = 1'b0;
  endtask

  task automatic random_accesses(input int n);
    adec_pkg::region_t r;
    logic              io;
    logic              wr;
    logic              mem_n;
    logic              in_n;
    repeat (n) begin
      r     = $random(seed);
      io    = ($random(seed) & 3) == 0;                      // One in four is I/O
      wr    = $random(seed);
      cpu_access(r, io, wr);
      r     = $random(seed);
      mem_n = ($random(seed) & 3) == 0;                      // Some non-memory cycles
      in_n  = ($random(seed) & 3) != 0;                      // Some input cycles
      bus_access(r, mem_n, in_n);
    end
  endtask

  // Switch toggle, new level reaches moff_n after the second sync edge
  task automatic set_switch(input logic on_n);
    @(posedge clk);
    #1;
    moff_sw_n = on_n;
    @(posedge clk);
    @(negedge clk);
    check_level(moff_n, ~on_n, "moff_n after first sync stage");
    @(posedge clk);
    @(negedge clk);
    check_level(moff_n, on_n, "moff_n after second sync stage");
    sw_on = on_n;
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while ({clrq_n, blrq_n, rlrq_n, cgnt_n, bgnt_n, rgnt_n} !== 6'h3f);
    repeat (2) @(posedge clk);                               // FSMs back to REQ_IDLE
  endtask

  function automatic req_pkg::lvl_n_t lrq_of(input int who);
    case (who)
      0:       return clrq_n;
      1:       return blrq_n;
      default: return rlrq_n;
    endcase
  endfunction

  task automatic set_grant(input int who, input req_pkg::lvl_n_t lvl);
    case (who)
      0:       cgnt_n = lvl;
      1:       bgnt_n = lvl;
      default: rgnt_n = lvl;
    endcase
  endtask

  // Ends just after edge k where the start condition is sampled
  task automatic fire_start(input int who);
    case (who)
      0: cpu_access(4'h0, 1'b0, 1'b0);                       // Region 0 read
      1: bus_access(4'hE, 1'b0, 1'b1);                       // Region 1 on inverted bus
      default: begin
        @(posedge clk);
        #1;
        refrq_n = 1'b0;
        @(posedge clk);
        #1;
        refrq_n = 1'b1;
      end
    endcase
  endtask

  task automatic handshake_seq(input int who, input string name);
    fire_start(who);
    @(negedge clk);
    check_level(lrq_of(who), req_pkg::LVL_OFF, {name, " at start edge"});
    @(negedge clk);
    check_level(lrq_of(who), req_pkg::LVL_ON, {name, " one cycle after start"});
    repeat (3) begin
      @(negedge clk);
      check_level(lrq_of(who), req_pkg::LVL_ON, {name, " held without grant"});
    end
    @(posedge clk);
    #1;
    set_grant(who, req_pkg::LVL_ON);
    @(negedge clk);
    check_level(lrq_of(who), req_pkg::LVL_ON, {name, " before grant is sampled"});
    @(negedge clk);
    check_level(lrq_of(who), req_pkg::LVL_OFF, {name, " released at grant edge"});
    repeat (2) begin
      @(negedge clk);
      check_level(lrq_of(who), req_pkg::LVL_OFF, {name, " off while grant low"});
    end
    @(posedge clk);
    #1;
    set_grant(who, req_pkg::LVL_OFF);
    repeat (3) begin
      @(negedge clk);
      check_level(lrq_of(who), req_pkg::LVL_OFF, {name, " off until a new hit"});
    end
    fire_start(who);
    @(negedge clk);
    @(negedge clk);
    check_level(lrq_of(who), req_pkg::LVL_ON, {name, " raised by new hit"});
    @(posedge clk);
    #1;
    set_grant(who, req_pkg::LVL_ON);
    @(posedge clk);
    #1;
    set_grant(who, req_pkg::LVL_OFF);
    repeat (2) @(posedge clk);
  endtask

  // Second CPU hit lands while the FSM sits in REQ_ASSERT
  task automatic dropped_hit_check();
    int falls_before;
    falls_before = clrq_falls;
    cpu_access(4'h0, 1'b0, 1'b0);
    @(negedge clk);
    @(negedge clk);
    check_level(clrq_n, req_pkg::LVL_ON, "first CPU request");
    cpu_access(4'h1, 1'b0, 1'b1);
    repeat (2) begin
      @(negedge clk);
      check_level(clrq_n, req_pkg::LVL_ON, "first CPU request pending");
    end
    @(posedge clk);
    #1;
    cgnt_n = 1'b0;
    @(posedge clk);
    #1;
    cgnt_n = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_level(clrq_n, req_pkg::LVL_OFF, "clrq_n after dropped hit");
    end
    check_count(clrq_falls - falls_before, 1, "CPU request cycles");
  endtask

  initial begin : stimulus
    adec_pkg::msize_t code;
    seed         = 32'ha0a62a8f;
    arst_n       = 1'b0;
    cfg_we       = 1'b0;
    cfg_msize    = '0;
    moff_sw_n    = 1'b1;
    cpu_strobe   = 1'b0;
    iorq_n       = 1'b1;
    write        = 1'b0;
    ppn          = '0;
    bus_strobe   = 1'b0;
    bmem_n       = 1'b1;
    binput_n     = 1'b1;
    bd_n         = '1;
    refrq_n      = 1'b1;
    cgnt_n       = 1'b1;
    bgnt_n       = 1'b1;
    rgnt_n       = 1'b1;
    auto_gnt     = 1'b0;
    cur_msize    = '0;
    sw_on        = 1'b1;
    cpu_bank_exp = '0;
    bus_bank_exp = '0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_level(clrq_n, req_pkg::LVL_OFF, "clrq_n after reset");
    check_level(blrq_n, req_pkg::LVL_OFF, "blrq_n after reset");
    check_level(rlrq_n, req_pkg::LVL_OFF, "rlrq_n after reset");
    check_level(crq_n, req_pkg::LVL_OFF, "crq_n after reset");
    check_level(mwrite_n, req_pkg::LVL_OFF, "mwrite_n after reset");
    check_level(moff_n, req_pkg::LVL_OFF, "moff_n after reset");
    check_region_limit(aok, 1'b0, "aok after reset");
    check_bank(bank, '0, "bank after reset");
    check_bank(bus_bank, '0, "bus_bank after reset");
    random_accesses(4);                                      // Unconfigured, no hits

    auto_gnt = 1'b1;
    for (int c = 0; c < 8; c++) begin
      code = (c < 4) ? c[1:0] : $random(seed);               // Every code, then random
      write_size(code);
      random_accesses(N_PER_CODE);
    end

    write_size(2'd3);
    set_switch(1'b0);
    random_accesses(N_PER_CODE);                             // Memory off
    set_switch(1'b1);
    random_accesses(N_PER_CODE);

    wait_idle();
    auto_gnt = 1'b0;
    handshake_seq(0, "clrq_n");
    handshake_seq(1, "blrq_n");
    handshake_seq(2, "rlrq_n");
    dropped_hit_check();

    repeat (3) @(posedge clk);
    if (cpu_exp_q.size() != 0 || bus_exp_q.size() != 0) begin
      errors++;
      $display("Expected results never checked: %0d CPU, %0d bus",
               cpu_exp_q.size(), bus_exp_q.size());
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_mem_adec

`default_nettype wire

// ==== flist.f ====
rtl/adec_pkg.sv
rtl/req_pkg.sv
rtl/mem_size_cfg.sv
rtl/cpu_adec.sv
rtl/bus_adec.sv
rtl/local_req_ctrl.sv
rtl/mem_adec.sv
sim/tb_mem_adec.sv

// ==== Bender.yml ====
package:
  name: mem_adec

sources:
  # Packages ahead of the modules that use them
  - rtl/adec_pkg.sv
  - rtl/req_pkg.sv
  - rtl/mem_size_cfg.sv
  - rtl/cpu_adec.sv
  - rtl/bus_adec.sv
  - rtl/local_req_ctrl.sv
  - rtl/mem_adec.sv
  - target: simulation
    files:
      - sim/tb_mem_adec.sv
